// ==== hdl/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

	// halfword count held in or taken from cir, 0 to 2
	typedef logic [1:0] hw_count_t;

	typedef logic [15:0] halfword_t;

	// ------------------------------------------------
	// opcode fields for the unconditional jumps

	// major opcode of JAL, bits 6:0
	localparam logic [6:0] OPC_JAL = 7'b1101111;

	// compressed quadrant 1, bits 1:0
	localparam logic [1:0] OPC_C_QUAD1 = 2'b01;

	// funct3 in bits 15:13 of quadrant 1
	localparam logic [2:0] OPC_CJ_FUNCT = 3'b101;
	localparam logic [2:0] OPC_CJAL_FUNCT = 3'b001;

	// length rule, both low bits set means a 32-bit instruction
	function automatic logic is_32bit(input logic [1:0] lsbs);
		return &lsbs;
	endfunction

endpackage

`default_nettype wire

// ==== hdl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

	// byte select, one bit per byte lane
	typedef logic [3:0] sel_t;

	// full word read
	localparam sel_t SEL_WORD = 4'b1111;

	// upper halfword only, lanes 3 and 2
	localparam sel_t SEL_UPPER_HALF = 4'b1100;

	// master state, one transfer in flight at most
	typedef enum logic {
		WB_IDLE,
		WB_BUSY
	} wb_state_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_queue #(
	parameter int W_ADDR = 32,
	parameter int FIFO_DEPTH = 2
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              push,
	input  logic [W_ADDR-1:0] wdata,
	input  logic              pop,
	input  logic              flush,
	output logic [W_ADDR-1:0] rdata,
	output logic              empty,
	output logic              full,
	output logic              almost_full
);

	// pointers carry one extra wrap bit above the index
	localparam int W_PTR = $clog2(FIFO_DEPTH) + 1;

	logic [W_ADDR-1:0] mem [FIFO_DEPTH];
	logic [W_PTR-1:0]  wptr;
	logic [W_PTR-1:0]  rptr;
	logic [W_PTR-1:0]  level;

	assign level = wptr - rptr;
	assign empty = wptr == rptr;
	assign full = level == W_PTR'(FIFO_DEPTH);
	// one slot left, or already full
	assign almost_full = level >= W_PTR'(FIFO_DEPTH - 1);

	// ------------------------------------------------
	// pointers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			// flush drops everything queued so far
			if (flush) begin
				rptr <= wptr;
			end else if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	// storage, depth is a power of two so modulo is a bit slice
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wptr % FIFO_DEPTH] <= wdata;
		end
	end

	// first-word-fall-through read
	assign rdata = mem[rptr % FIFO_DEPTH];

	// ------------------------------------------------
	// checks

	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
		!(pop && empty));

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		!(push && full));

endmodule

`default_nettype wire

// ==== hdl/fetch_frontend.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_frontend #(
	parameter int W_ADDR = 32,
	parameter int FIFO_DEPTH = 2,
	parameter logic [W_ADDR-1:0] RESET_PC = '0
) (
	input  logic                clk,
	input  logic                rst_n,
	// request side towards the bus master
	output logic                mem_size,
	output logic [W_ADDR-1:0]   mem_addr,
	output logic                mem_addr_vld,
	input  logic                mem_addr_rdy,
	input  logic [W_ADDR-1:0]   mem_data,
	input  logic                mem_data_vld,
	// jump request from decode
	input  logic [W_ADDR-1:0]   jump_target,
	input  logic                jump_target_vld,
	output logic                jump_target_rdy,
	// current instruction register
	output logic [31:0]         cir,
	output fetch_pkg::hw_count_t cir_vld,
	input  fetch_pkg::hw_count_t cir_use
);

	import fetch_pkg::*;

	logic              jump_now;
	logic              fifo_push;
	logic              fifo_pop;
	logic [W_ADDR-1:0] fifo_rdata;
	logic              fifo_empty;
	logic              fifo_full;
	logic              fifo_almost_full;
	logic [W_ADDR-1:0] fetch_data;
	logic              fetch_data_vld;

	assign jump_now = jump_target_vld && jump_target_rdy;

	fetch_queue #(
		.W_ADDR(W_ADDR),
		.FIFO_DEPTH(FIFO_DEPTH)
	) i_fetch_queue (
		.clk(clk),
		.rst_n(rst_n),
		.push(fifo_push),
		.wdata(mem_data),
		.pop(fifo_pop),
		.flush(jump_now),
		.rdata(fifo_rdata),
		.empty(fifo_empty),
		.full(fifo_full),
		.almost_full(fifo_almost_full)
	);

	// ------------------------------------------------
	// bus request side

	logic              addr_hold;
	logic              pending;
	logic              flush_pending;
	logic [W_ADDR-1:0] fetch_addr;
	logic              fetch_stall;
	logic              unaligned_aph;
	logic              unaligned_dph;

	// request left waiting last cycle must be held unchanged
	// no other jump is taken while it waits
	assign jump_target_rdy = !addr_hold;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addr_hold <= 1'b0;
			pending <= 1'b0;
			flush_pending <= 1'b0;
		end else begin
			addr_hold <= mem_addr_vld && !mem_addr_rdy;
			// master takes a new request only when idle so never both at once
			if (mem_addr_vld && mem_addr_rdy) begin
				pending <= 1'b1;
			end else if (mem_data_vld) begin
				pending <= 1'b0;
			end
			// data of a fetch still in flight at the jump is wrong-path
			if (jump_now) begin
				flush_pending <= pending && !mem_data_vld;
			end else if (mem_data_vld) begin
				flush_pending <= 1'b0;
			end
		end
	end

	// runs ahead of the PC in whole words
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= {RESET_PC[W_ADDR-1:2], 2'b00};
		end else if (jump_now) begin
			// skip the target word if the bus took it right away
			fetch_addr <= {jump_target[W_ADDR-1:2] + (W_ADDR-2)'(mem_addr_rdy), 2'b00};
		end else if (mem_addr_vld && mem_addr_rdy) begin
			fetch_addr <= fetch_addr + W_ADDR'(4);
		end
	end

	// a second request may wait behind the one in flight
	// only while the queue can take both words
	assign fetch_stall = fifo_full || (fifo_almost_full && pending);

	// aph covers an unaligned jump request left waiting on the bus
	// dph marks the first word back so only its upper half is used
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unaligned_aph <= 1'b0;
			unaligned_dph <= 1'b0;
		end else begin
			if (mem_addr_vld && mem_addr_rdy) begin
				unaligned_aph <= 1'b0;
			end
			if (fetch_data_vld) begin
				unaligned_dph <= 1'b0;
			end
			if (jump_now && jump_target[1]) begin
				unaligned_aph <= !mem_addr_rdy;
				unaligned_dph <= 1'b1;
			end
		end
	end

	// held request first, then jump, then sequential fetch
	always_comb begin
		mem_addr = fetch_addr;
		mem_size = 1'b1;
		mem_addr_vld = 1'b1;
		if (addr_hold) begin
			mem_addr = {fetch_addr[W_ADDR-1:2], unaligned_aph, 1'b0};
			mem_size = !unaligned_aph;
		end else if (jump_target_vld) begin
			mem_addr = jump_target;
			// unaligned target becomes a single halfword read
			mem_size = !jump_target[1];
		end else if (fetch_stall) begin
			mem_addr_vld = 1'b0;
		end
	end

	// ------------------------------------------------
	// instruction assembly

	// buf_level counts valid halfwords in {hwbuf, cir} up to 3
	logic [1:0]        buf_level;
	logic [1:0]        level_after_use;
	logic [1:0]        buf_level_next;
	halfword_t         hwbuf;
	logic [47:0]       shifted;
	logic [47:0]       assembled;
	logic              take;

	// queue first and bus data only when the queue is empty
	assign fetch_data = fifo_empty ? mem_data : fifo_rdata;
	assign fetch_data_vld = !fifo_empty || (mem_data_vld && !flush_pending);

	// move leftover halfwords down over what decode consumed
	always_comb begin
		case (cir_use)
			2'd1: shifted = {hwbuf, hwbuf, cir[31:16]};
			2'd2: shifted = {hwbuf, hwbuf, hwbuf};
			default: shifted = {hwbuf, cir};
		endcase
	end

	assign level_after_use = buf_level - cir_use;

	// room for a full word only with at most one halfword left
	assign take = fetch_data_vld && !level_after_use[1] && !jump_now;

	always_comb begin
		assembled = shifted;
		if (take) begin
			if (unaligned_dph) begin
				assembled = {shifted[47:16], fetch_data[31:16]};
			end else if (level_after_use[0]) begin
				assembled = {fetch_data[31:0], shifted[15:0]};
			end else begin
				assembled = {shifted[47:32], fetch_data[31:0]};
			end
		end
	end

	always_comb begin
		if (jump_now) begin
			buf_level_next = 2'd0;
		end else if (take) begin
			buf_level_next = unaligned_dph ? 2'd1 : level_after_use + 2'd2;
		end else begin
			buf_level_next = level_after_use;
		end
	end

	// queue word popped when used and bus word queued when not
	assign fifo_pop = take && !fifo_empty;
	assign fifo_push = mem_data_vld && !flush_pending && !jump_now && !(take && fifo_empty);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			buf_level <= 2'd0;
			cir_vld <= 2'd0;
		end else begin
			buf_level <= buf_level_next;
			// cir shows at most two of the buffered halfwords
			cir_vld <= buf_level_next[1] ? 2'd2 : buf_level_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= assembled;
	end

	// ------------------------------------------------
	// checks

	a_use_le_vld: assert property (@(posedge clk) disable iff (!rst_n)
		cir_use <= cir_vld);

	a_drop_le_pending: assert property (@(posedge clk) disable iff (!rst_n)
		flush_pending |-> pending);

endmodule

`default_nettype wire

// ==== hdl/wb_fetch_master.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_fetch_master #(
	parameter int W_ADDR = 32
) (
	input  logic              clk,
	input  logic              rst_n,
	// request side from the front end
	input  logic              mem_size,
	input  logic [W_ADDR-1:0] mem_addr,
	input  logic              mem_addr_vld,
	output logic              mem_addr_rdy,
	output logic [W_ADDR-1:0] mem_data,
	output logic              mem_data_vld,
	// wishbone classic, reads only
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic [W_ADDR-1:0] wb_adr,
	output wb_pkg::sel_t      wb_sel,
	input  logic [W_ADDR-1:0] wb_dat,
	input  logic              wb_ack
);

	import wb_pkg::*;

	wb_state_t state;

	// accept only into an idle master
	assign mem_addr_rdy = state == WB_IDLE;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= WB_IDLE;
		end else begin
			case (state)
				WB_IDLE: if (mem_addr_vld) state <= WB_BUSY;
				// cycle ends on ack, next one starts a clock later at earliest
				WB_BUSY: if (wb_ack) state <= WB_IDLE;
				default: state <= WB_IDLE;
			endcase
		end
	end

	// address and select latched on accept, stable through the cycle
	always_ff @(posedge clk) begin
		if (mem_addr_vld && mem_addr_rdy) begin
			wb_adr <= mem_addr;
			// halfword read only for the upper half of a word
			wb_sel <= (!mem_size && mem_addr[1]) ? SEL_UPPER_HALF : SEL_WORD;
		end
	end

	assign wb_cyc = state == WB_BUSY;
	assign wb_stb = state == WB_BUSY;

	assign mem_data = wb_dat;
	assign mem_data_vld = wb_ack && (state == WB_BUSY);

	a_adr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_sel));

endmodule

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decode #(
	parameter int W_ADDR = 32,
	parameter logic [W_ADDR-1:0] RESET_PC = '0
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          cir,
	input  fetch_pkg::hw_count_t cir_vld,
	output fetch_pkg::hw_count_t cir_use,
	output logic [W_ADDR-1:0]    jump_target,
	output logic                 jump_target_vld,
	input  logic                 jump_target_rdy,
	input  logic                 stall,
	output logic                 retire_vld,
	output logic [W_ADDR-1:0]    retire_pc,
	output logic [31:0]          retire_instr,
	output logic                 retire_is_32
);

	import fetch_pkg::*;

	logic [W_ADDR-1:0] pc;
	logic              instr_32;
	hw_count_t         need;
	logic              have;
	logic              is_jal;
	logic              is_cj;
	logic              is_jump;
	logic [31:0]       imm;
	logic              fire;

	// ------------------------------------------------
	// length and jump decode

	assign instr_32 = is_32bit(cir[1:0]);
	assign need = instr_32 ? 2'd2 : 2'd1;
	assign have = cir_vld >= need;

	assign is_jal = instr_32 && cir[6:0] == OPC_JAL;
	// C.J and C.JAL share the immediate layout
	assign is_cj = cir[1:0] == OPC_C_QUAD1 &&
		(cir[15:13] == OPC_CJ_FUNCT || cir[15:13] == OPC_CJAL_FUNCT);
	assign is_jump = have && (is_jal || is_cj);

	always_comb begin
		if (is_jal) begin
			imm = {{11{cir[31]}}, cir[31], cir[19:12], cir[20], cir[30:21], 1'b0};
		end else begin
			// CJ format, offset bits scattered over 12:2
			imm = {{20{cir[12]}}, cir[12], cir[8], cir[10:9], cir[6], cir[7],
				cir[2], cir[11], cir[5:3], 1'b0};
		end
	end

	assign jump_target = pc + W_ADDR'(signed'(imm));

	// jump waits for the front end, nothing else is consumed meanwhile
	assign jump_target_vld = is_jump && !stall;

	assign fire = have && !stall && (!is_jump || jump_target_rdy);
	assign cir_use = fire ? need : 2'd0;

	// ------------------------------------------------
	// pc and retire register

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= RESET_PC;
		end else if (fire) begin
			pc <= is_jump ? jump_target : pc + (instr_32 ? W_ADDR'(4) : W_ADDR'(2));
		end
	end

	// one pulse per consumed instruction, payload held otherwise
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_vld <= 1'b0;
		end else begin
			retire_vld <= fire;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			retire_pc <= pc;
			// upper half zeroed for a 16-bit instruction
			retire_instr <= {instr_32 ? cir[31:16] : 16'h0000, cir[15:0]};
			retire_is_32 <= instr_32;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
	parameter int W_ADDR = 32,
	parameter int FIFO_DEPTH = 2,
	parameter logic [W_ADDR-1:0] RESET_PC = '0
) (
	input  logic              clk,
	input  logic              rst_n,
	// wishbone classic master, reads only
	output logic              wb_cyc,
	output logic              wb_stb,
	output logic [W_ADDR-1:0] wb_adr,
	output wb_pkg::sel_t      wb_sel,
	input  logic [W_ADDR-1:0] wb_dat,
	input  logic              wb_ack,
	// back-pressure and retire port
	input  logic              stall,
	output logic              retire_vld,
	output logic [W_ADDR-1:0] retire_pc,
	output logic [31:0]       retire_instr,
	output logic              retire_is_32
);

	import fetch_pkg::*;

	logic              mem_size;
	logic [W_ADDR-1:0] mem_addr;
	logic              mem_addr_vld;
	logic              mem_addr_rdy;
	logic [W_ADDR-1:0] mem_data;
	logic              mem_data_vld;
	logic [W_ADDR-1:0] jump_target;
	logic              jump_target_vld;
	logic              jump_target_rdy;
	logic [31:0]       cir;
	hw_count_t         cir_vld;
	hw_count_t         cir_use;

	fetch_frontend #(
		.W_ADDR(W_ADDR),
		.FIFO_DEPTH(FIFO_DEPTH),
		.RESET_PC(RESET_PC)
	) i_fetch_frontend (
		.clk(clk),
		.rst_n(rst_n),
		.mem_size(mem_size),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.mem_addr_rdy(mem_addr_rdy),
		.mem_data(mem_data),
		.mem_data_vld(mem_data_vld),
		.jump_target(jump_target),
		.jump_target_vld(jump_target_vld),
		.jump_target_rdy(jump_target_rdy),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_use(cir_use)
	);

	wb_fetch_master #(
		.W_ADDR(W_ADDR)
	) i_wb_fetch_master (
		.clk(clk),
		.rst_n(rst_n),
		.mem_size(mem_size),
		.mem_addr(mem_addr),
		.mem_addr_vld(mem_addr_vld),
		.mem_addr_rdy(mem_addr_rdy),
		.mem_data(mem_data),
		.mem_data_vld(mem_data_vld),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack)
	);

	instr_decode #(
		.W_ADDR(W_ADDR),
		.RESET_PC(RESET_PC)
	) i_instr_decode (
		.clk(clk),
		.rst_n(rst_n),
		.cir(cir),
		.cir_vld(cir_vld),
		.cir_use(cir_use),
		.jump_target(jump_target),
		.jump_target_vld(jump_target_vld),
		.jump_target_rdy(jump_target_rdy),
		.stall(stall),
		.retire_vld(retire_vld),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_is_32(retire_is_32)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_fetch_top;

	import fetch_pkg::*;
	import wb_pkg::*;

	localparam int W_ADDR = 32;
	localparam int FIFO_DEPTH = 2;
	localparam logic [W_ADDR-1:0] RESET_PC = 32'h0000_0080;
	// memory size in halfwords, a power of two so addresses wrap
	localparam int MEM_HW = 4096;
	localparam int N_RETIRE = 300;
	localparam int IDLE_LIMIT = 200;

	logic              clk = 1'b0;
	logic              rst_n = 1'b0;
	logic              stall = 1'b0;
	logic              wb_ack = 1'b0;
	logic [W_ADDR-1:0] wb_dat = '0;
	logic              wb_cyc;
	logic              wb_stb;
	logic [W_ADDR-1:0] wb_adr;
	sel_t              wb_sel;
	logic              retire_vld;
	logic [W_ADDR-1:0] retire_pc;
	logic [31:0]       retire_instr;
	logic              retire_is_32;

	integer            seed = 32'h32b74361;
	logic [15:0]       mem_hw [MEM_HW];
	// forward offset of the jump starting at each halfword, 0 for anything else
	int                jump_off [MEM_HW];

	logic              armed;
	logic [1:0]        wait_left;

	logic [W_ADDR-1:0] exp_pc;
	int                retired;
	int                chk_idx;
	logic [15:0]       chk_lo;
	logic [15:0]       chk_hi;
	logic              chk_len32;

	fetch_top #(
		.W_ADDR(W_ADDR),
		.FIFO_DEPTH(FIFO_DEPTH),
		.RESET_PC(RESET_PC)
	) i_fetch_top (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_adr(wb_adr),
		.wb_sel(wb_sel),
		.wb_dat(wb_dat),
		.wb_ack(wb_ack),
		.stall(stall),
		.retire_vld(retire_vld),
		.retire_pc(retire_pc),
		.retire_instr(retire_instr),
		.retire_is_32(retire_is_32)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// ------------------------------------------------
	// helpers

	task automatic report_and_stop(input string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic int hw_index(input logic [W_ADDR-1:0] addr);
		return int'((addr >> 1) & (MEM_HW - 1));
	endfunction

	// bus returns the whole word, the front end picks the half it needs
	function automatic logic [31:0] word_at(input logic [W_ADDR-1:0] addr);
		int idx;
		idx = hw_index({addr[W_ADDR-1:2], 2'b00});
		return {mem_hw[idx + 1], mem_hw[idx]};
	endfunction

	// J-type layout imm[20|10:1|11|19:12], link register x1
	function automatic logic [31:0] encode_jal(input int off);
		logic [20:0] imm;
		imm = 21'(off);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
	endfunction

	// CJ layout imm[11|4|9:8|10|6|7|3:1|5] in bits 12:2
	function automatic logic [15:0] encode_cj(input int off, input logic link);
		logic [11:0] imm;
		imm = 12'(off);
		return {link ? OPC_CJAL_FUNCT : OPC_CJ_FUNCT, imm[11], imm[4], imm[9:8],
			imm[10], imm[6], imm[7], imm[3:1], imm[5], OPC_C_QUAD1};
	endfunction

	// program image, mostly alu ops with an occasional forward jump
	task automatic fill_memory();
		int          i;
		int          off;
		logic [31:0] r;
		logic [31:0] r2;
		logic [31:0] jal;
		i = 0;
		while (i < MEM_HW) begin
			r = $random(seed);
			r2 = $random(seed);
			off = 4 + 2 * int'(r2[7:4]);
			jump_off[i] = 0;
			if (i == MEM_HW - 1 || r[3:0] < 4'd9) begin
				// 16-bit alu in quadrant 0 or 2, never a jump
				mem_hw[i] = {r[31:18], r[17], 1'b0};
				i = i + 1;
			end else if (r[3:0] < 4'd14) begin
				// 32-bit OP, upper half reads as a plain 16-bit op if jumped into
				mem_hw[i] = {r[31:23], 7'b0110011};
				mem_hw[i + 1] = {r2[31:18], r2[17], 1'b0};
				jump_off[i + 1] = 0;
				i = i + 2;
			end else if (r[3:0] == 4'd14) begin
				jal = encode_jal(off);
				mem_hw[i] = jal[15:0];
				mem_hw[i + 1] = jal[31:16];
				jump_off[i] = off;
				jump_off[i + 1] = 0;
				i = i + 2;
			end else begin
				// C.J or C.JAL
				mem_hw[i] = encode_cj(off, r2[0]);
				jump_off[i] = off;
				i = i + 1;
			end
		end
	endtask

	// ------------------------------------------------
	// wishbone slave with 0 to 3 wait states, and stall

	always @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			armed <= 1'b0;
			wait_left <= 2'd0;
			stall <= 1'b0;
		end else begin
			// stall about one cycle in four
			stall <= ($random(seed) & 3) == 0;
			if (wb_ack) begin
				wb_ack <= 1'b0;
			end else if (wb_cyc && wb_stb) begin
				if (!armed) begin
					armed <= 1'b1;
					wait_left <= 2'($random(seed));
				end else if (wait_left != 2'd0) begin
					wait_left <= wait_left - 2'd1;
				end else begin
					armed <= 1'b0;
					wb_ack <= 1'b1;
					wb_dat <= word_at(wb_adr);
				end
			end
		end
	end

	// ------------------------------------------------
	// bus and stall checks

	a_stb_with_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_cyc)
		else report_and_stop($sformatf("[FAIL] %0t ns: wb_stb high without wb_cyc", $time));

	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel))
		else report_and_stop($sformatf("[FAIL] %0t ns: request changed before ack", $time));

	a_sel_rule: assert property (@(posedge clk) disable iff (!rst_n)
		wb_stb |-> wb_sel == (wb_adr[1] ? SEL_UPPER_HALF : SEL_WORD))
		else report_and_stop($sformatf("[FAIL] %0t ns: wb_sel %b for wb_adr %h",
			$time, wb_sel, wb_adr));

	a_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> !retire_vld)
		else report_and_stop($sformatf("[FAIL] %0t ns: retire during stall", $time));

	// retire checks, sampled mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (rst_n && retire_vld) begin
			chk_idx = hw_index(retire_pc);
			chk_lo = mem_hw[chk_idx];
			chk_hi = mem_hw[(chk_idx + 1) % MEM_HW];
			chk_len32 = is_32bit(chk_lo[1:0]);
			if (retired == 0) begin
				assert (retire_pc == RESET_PC)
					else report_and_stop($sformatf("[FAIL] %0t ns: first retire_pc %h, expected %h",
						$time, retire_pc, RESET_PC));
			end
			assert (retire_pc == exp_pc)
				else report_and_stop($sformatf("[FAIL] %0t ns: retire_pc %h, expected %h",
					$time, retire_pc, exp_pc));
			assert (retire_is_32 == chk_len32)
				else report_and_stop($sformatf("[FAIL] %0t ns: retire_is_32 %b at pc %h",
					$time, retire_is_32, retire_pc));
			assert (retire_instr[15:0] == chk_lo && (!chk_len32 || retire_instr[31:16] == chk_hi))
				else report_and_stop($sformatf("[FAIL] %0t ns: retire_instr %h at pc %h",
					$time, retire_instr, retire_pc));
			// a jump redirects, anything else falls through by its length
			if (jump_off[chk_idx] != 0) begin
				exp_pc = retire_pc + W_ADDR'(jump_off[chk_idx]);
			end else begin
				exp_pc = retire_pc + (chk_len32 ? W_ADDR'(4) : W_ADDR'(2));
			end
			retired = retired + 1;
		end
	end

	// ------------------------------------------------
	// main sequence

	initial begin
		int idle;
		int last;
		exp_pc = RESET_PC;
		retired = 0;
		idle = 0;
		last = 0;
		fill_memory();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		// gives up when retirement stops making progress
		while (retired < N_RETIRE && idle < IDLE_LIMIT) begin
			@(posedge clk);
			if (retired != last) begin
				idle = 0;
				last = retired;
			end else begin
				idle = idle + 1;
			end
		end
		if (retired >= N_RETIRE) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			report_and_stop($sformatf("timeout: no instruction retired for %0d cycles after %0d",
				idle, retired));
		end
	end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/fetch_pkg.sv
hdl/wb_pkg.sv
hdl/fetch_queue.sv
hdl/fetch_frontend.sv
hdl/wb_fetch_master.sv
hdl/instr_decode.sv
hdl/fetch_top.sv
testbench/tb_fetch_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_fetch_top
RTL_TOP    := fetch_top
FILELIST   := list.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := ERRORS FOUND
PASS_MSG   := NO ERRORS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
